// File: logic/core_pkg.sv
//////////////////////////////////////////////////////////////////////
// Shared core definitions
// Word and register index types, instruction word views
// Major opcodes, ALU operation encodings, canonical no-op
//////////////////////////////////////////////////////////////////////

package core_pkg;

  // Data and address width
  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0]      reg_addr_t;

  //////////////////////////////////////////////////////////////////////
  // Instruction formats
  //////////////////////////////////////////////////////////////////////

  // Register-register layout
  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    logic [6:0] opcode;
  } r_view_t;

  // Immediate layout, also carries the LUI upper bits
  typedef struct packed {
    logic [11:0] imm;
    reg_addr_t   rs1;
    logic [2:0]  funct3;
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } i_view_t;

  // Store layout, immediate split around rs2/rs1
  typedef struct packed {
    logic [6:0] imm_hi;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_view_t;

  // One fetched word, decoded through the view its opcode picks
  typedef union packed {
    r_view_t r_view;
    i_view_t i_view;
    s_view_t s_view;
  } instr_u;

  // Major opcodes handled here
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_STORE  = 7'b0100011
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD    = 3'd0,
    ALU_SUB    = 3'd1,
    ALU_AND    = 3'd2,
    ALU_OR     = 3'd3,
    ALU_XOR    = 3'd4,
    ALU_SLT    = 3'd5,
    ALU_PASS_B = 3'd6
  } alu_op_e;

  // ADDI x0, x0, 0
  localparam word_t NOP_INSTR = 32'h0000_0013;

endpackage

// File: logic/if_id_if.sv
//////////////////////////////////////////////////////////////////////
// Fetch to decode handoff
// Fetched word and its PC under a valid/ready handshake
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

interface if_id_if;
  import core_pkg::*;

  // Handshake
  logic   valid;
  logic   ready;

  // Payload, stable while valid waits for ready
  word_t  pc;
  instr_u instr;

  modport fetch  (output valid, pc, instr, input ready);
  modport decode (input valid, pc, instr, output ready);

endinterface

// File: logic/id_ex_if.sv
//////////////////////////////////////////////////////////////////////
// Decode to execute handoff
// Decoded ALU operation, operands and write-back or store control
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

interface id_ex_if;
  import core_pkg::*;

  // Handshake
  logic      valid;
  logic      ready;

  // Operation and operands
  alu_op_e   alu_op;
  word_t     op_a;
  word_t     op_b;
  word_t     store_data;

  // Destination and kind
  reg_addr_t rd;
  logic      rd_we;
  logic      is_store;

  modport decode  (output valid, alu_op, op_a, op_b, store_data, rd, rd_we, is_store,
                   input ready);
  modport execute (input valid, alu_op, op_a, op_b, store_data, rd, rd_we, is_store,
                   output ready);

endinterface

// File: logic/fetch_stage.sv
//////////////////////////////////////////////////////////////////////
// Instruction fetch stage
// OBI instruction master with credit-limited outstanding requests
// In-order response buffer feeding the decode handshake
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module fetch_stage #(
  parameter int FETCH_DEPTH = 2
) (
  input  logic            clk_i,
  input  logic            rst_i,
  input  logic            fetch_enable_i,
  input  core_pkg::word_t boot_addr_i,

  // Instruction bus
  output logic            instr_req_o,
  output core_pkg::word_t instr_addr_o,
  input  logic            instr_gnt_i,
  input  logic            instr_rvalid_i,
  input  core_pkg::word_t instr_rdata_i,

  if_id_if.fetch          if_id_o
);
  import core_pkg::*;

  localparam int PTR_W = (FETCH_DEPTH > 1) ? $clog2(FETCH_DEPTH) : 1;
  localparam int CNT_W = $clog2(FETCH_DEPTH + 1);

  word_t            fetch_addr_q;
  word_t            resp_pc_q;
  logic             req_hold_q;
  logic [CNT_W-1:0] outstanding_q;
  logic [CNT_W-1:0] buf_cnt_q;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W:0]   in_flight;
  logic             req_accept;
  logic             pop;

  // Buffer storage
  word_t  pc_mem    [FETCH_DEPTH];
  instr_u instr_mem [FETCH_DEPTH];

  function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(FETCH_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // Granted but unanswered requests plus buffered words
  assign in_flight = outstanding_q + buf_cnt_q;

  // Keep req up once raised, until granted
  assign instr_req_o  = (fetch_enable_i || req_hold_q) && (in_flight < FETCH_DEPTH);
  assign instr_addr_o = fetch_addr_q;
  assign req_accept   = instr_req_o && instr_gnt_i;
  assign pop          = if_id_o.valid && if_id_o.ready;

  //////////////////////////////////////////////////////////////////////
  // Request side and counters
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      fetch_addr_q  <= boot_addr_i;
      resp_pc_q     <= boot_addr_i;
      req_hold_q    <= 1'b0;
      outstanding_q <= '0;
      buf_cnt_q     <= '0;
      wr_ptr_q      <= '0;
      rd_ptr_q      <= '0;
    end else begin
      req_hold_q    <= instr_req_o && !instr_gnt_i;
      outstanding_q <= outstanding_q + CNT_W'(req_accept) - CNT_W'(instr_rvalid_i);
      buf_cnt_q     <= buf_cnt_q + CNT_W'(instr_rvalid_i) - CNT_W'(pop);
      if (req_accept) begin
        fetch_addr_q <= fetch_addr_q + 32'd4;
      end
      // Responses return in order, so their PC simply counts up
      if (instr_rvalid_i) begin
        resp_pc_q <= resp_pc_q + 32'd4;
        wr_ptr_q  <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
    end
  end

  // Credit scheme guarantees a free slot here
  always_ff @(posedge clk_i) begin
    if (instr_rvalid_i) begin
      pc_mem[wr_ptr_q]    <= resp_pc_q;
      instr_mem[wr_ptr_q] <= instr_rdata_i;
    end
  end

  // Head of buffer to decode
  assign if_id_o.valid = (buf_cnt_q != '0);
  assign if_id_o.pc    = pc_mem[rd_ptr_q];
  assign if_id_o.instr = instr_mem[rd_ptr_q];

endmodule

// File: logic/decode_stage.sv
//////////////////////////////////////////////////////////////////////
// Instruction decode stage
// Format decode, immediate build, operand read with forwarding
// ID/EX pipeline register under valid/ready
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module decode_stage (
  input  logic                clk_i,
  input  logic                rst_i,

  if_id_if.decode             if_id_i,
  id_ex_if.decode             id_ex_o,

  // Register file read ports
  output core_pkg::reg_addr_t raddr_a_o,
  output core_pkg::reg_addr_t raddr_b_o,
  input  core_pkg::word_t     rdata_a_i,
  input  core_pkg::word_t     rdata_b_i,

  // Write-back, also the forwarding source
  input  logic                wb_we_i,
  input  core_pkg::reg_addr_t wb_addr_i,
  input  core_pkg::word_t     wb_data_i
);
  import core_pkg::*;

  instr_u  instr;
  word_t   rs1_val;
  word_t   rs2_val;
  word_t   imm_i;
  word_t   imm_s;
  word_t   imm_u;
  logic    pc_aligned;
  alu_op_e dec_alu_op;
  word_t   dec_op_b;
  logic    dec_rd_we;
  logic    dec_is_store;

  // Write in flight this cycle wins over the stale register value
  function automatic word_t fwd_sel(reg_addr_t addr, word_t rf_data, logic we,
                                    reg_addr_t waddr, word_t wdata);
    return (we && (waddr == addr) && (addr != '0)) ? wdata : rf_data;
  endfunction

  assign instr      = if_id_i.instr;
  assign pc_aligned = (if_id_i.pc[1:0] == 2'b00);

  // rs1/rs2 sit at the same bits in every kept format
  assign raddr_a_o = instr.r_view.rs1;
  assign raddr_b_o = instr.r_view.rs2;
  assign rs1_val   = fwd_sel(raddr_a_o, rdata_a_i, wb_we_i, wb_addr_i, wb_data_i);
  assign rs2_val   = fwd_sel(raddr_b_o, rdata_b_i, wb_we_i, wb_addr_i, wb_data_i);

  // Immediates
  assign imm_i = {{20{instr.i_view.imm[11]}}, instr.i_view.imm};
  assign imm_s = {{20{instr.s_view.imm_hi[6]}}, instr.s_view.imm_hi, instr.s_view.imm_lo};
  assign imm_u = {instr.i_view.imm, instr.i_view.rs1, instr.i_view.funct3, 12'h000};

  //////////////////////////////////////////////////////////////////////
  // Decoder
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    dec_alu_op   = ALU_ADD;
    dec_op_b     = imm_i;
    dec_rd_we    = 1'b0;
    dec_is_store = 1'b0;
    case (instr.r_view.opcode)
      OPC_OP: begin
        dec_op_b = rs2_val;
        if (instr.r_view.funct7 == 7'b0000000) begin
          dec_rd_we = 1'b1;
          case (instr.r_view.funct3)
            3'b000:  dec_alu_op = ALU_ADD;
            3'b010:  dec_alu_op = ALU_SLT;
            3'b100:  dec_alu_op = ALU_XOR;
            3'b110:  dec_alu_op = ALU_OR;
            3'b111:  dec_alu_op = ALU_AND;
            default: dec_rd_we  = 1'b0;
          endcase
        end else if (instr.r_view.funct7 == 7'b0100000 && instr.r_view.funct3 == 3'b000) begin
          dec_alu_op = ALU_SUB;
          dec_rd_we  = 1'b1;
        end
      end
      OPC_OP_IMM: begin
        dec_rd_we = 1'b1;
        case (instr.i_view.funct3)
          3'b000:  dec_alu_op = ALU_ADD;
          3'b100:  dec_alu_op = ALU_XOR;
          3'b110:  dec_alu_op = ALU_OR;
          3'b111:  dec_alu_op = ALU_AND;
          default: dec_rd_we  = 1'b0;
        endcase
      end
      OPC_LUI: begin
        dec_alu_op = ALU_PASS_B;
        dec_op_b   = imm_u;
        dec_rd_we  = 1'b1;
      end
      // SW only, address is rs1 + offset
      OPC_STORE: begin
        dec_op_b     = imm_s;
        dec_is_store = (instr.s_view.funct3 == 3'b010);
      end
      default: ;
    endcase
    // Misaligned fetch retires as a no-op
    if (!pc_aligned) begin
      dec_rd_we    = 1'b0;
      dec_is_store = 1'b0;
    end
  end

  // Accept when empty or draining this cycle
  assign if_id_i.ready = !id_ex_o.valid || id_ex_o.ready;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      id_ex_o.valid <= 1'b0;
    end else if (if_id_i.valid && if_id_i.ready) begin
      id_ex_o.valid <= 1'b1;
    end else if (id_ex_o.ready) begin
      id_ex_o.valid <= 1'b0;
    end
  end

  // Payload
  always_ff @(posedge clk_i) begin
    if (if_id_i.valid && if_id_i.ready) begin
      id_ex_o.alu_op     <= dec_alu_op;
      id_ex_o.op_a       <= rs1_val;
      id_ex_o.op_b       <= dec_op_b;
      id_ex_o.store_data <= rs2_val;
      id_ex_o.rd         <= instr.r_view.rd;
      id_ex_o.rd_we      <= dec_rd_we;
      id_ex_o.is_store   <= dec_is_store;
    end
  end

endmodule

// File: logic/register_file.sv
//////////////////////////////////////////////////////////////////////
// General purpose register file
// 31 flip-flop registers, x0 hardwired to zero
// Two combinational read ports, one write port
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module register_file (
  input  logic                clk_i,

  // Read ports
  input  core_pkg::reg_addr_t raddr_a_i,
  input  core_pkg::reg_addr_t raddr_b_i,
  output core_pkg::word_t     rdata_a_o,
  output core_pkg::word_t     rdata_b_o,

  // Write port
  input  logic                we_i,
  input  core_pkg::reg_addr_t waddr_i,
  input  core_pkg::word_t     wdata_i
);
  import core_pkg::*;

  // No storage behind x0
  word_t regs_q [1:31];

  function automatic word_t rd_reg(reg_addr_t addr, word_t val);
    return (addr == '0) ? '0 : val;
  endfunction

  always_ff @(posedge clk_i) begin
    if (we_i && waddr_i != '0) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  assign rdata_a_o = rd_reg(raddr_a_i, regs_q[raddr_a_i]);
  assign rdata_b_o = rd_reg(raddr_b_i, regs_q[raddr_b_i]);

endmodule

// File: logic/execute_stage.sv
//////////////////////////////////////////////////////////////////////
// Execute and write-back stage
// ALU over the held ID/EX item, register write-back
// Store issue on the OBI data bus, request phase only
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module execute_stage (
  id_ex_if.execute            id_ex_i,

  // Register file write port
  output logic                wb_we_o,
  output core_pkg::reg_addr_t wb_addr_o,
  output core_pkg::word_t     wb_data_o,

  // Data bus
  output logic                data_req_o,
  output logic                data_we_o,
  output core_pkg::word_t     data_addr_o,
  output core_pkg::word_t     data_wdata_o,
  input  logic                data_gnt_i
);
  import core_pkg::*;

  word_t alu_result;
  logic  store_pending;

  //////////////////////////////////////////////////////////////////////
  // ALU
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (id_ex_i.alu_op)
      ALU_ADD:    alu_result = id_ex_i.op_a + id_ex_i.op_b;
      ALU_SUB:    alu_result = id_ex_i.op_a - id_ex_i.op_b;
      ALU_AND:    alu_result = id_ex_i.op_a & id_ex_i.op_b;
      ALU_OR:     alu_result = id_ex_i.op_a | id_ex_i.op_b;
      ALU_XOR:    alu_result = id_ex_i.op_a ^ id_ex_i.op_b;
      // Signed compare, result is 0 or 1
      ALU_SLT:    alu_result = {31'b0, $signed(id_ex_i.op_a) < $signed(id_ex_i.op_b)};
      ALU_PASS_B: alu_result = id_ex_i.op_b;
      default:    alu_result = '0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Retirement
  //////////////////////////////////////////////////////////////////////

  // Store held in place until the bus grants it
  assign store_pending = id_ex_i.valid && id_ex_i.is_store;

  // Non-stores retire the cycle they show up
  assign id_ex_i.ready = !store_pending || data_gnt_i;

  // Write-back, also seen by decode as forwarding source
  assign wb_we_o   = id_ex_i.valid && id_ex_i.rd_we;
  assign wb_addr_o = id_ex_i.rd;
  assign wb_data_o = alu_result;

  // Store request
  // Address from the ADD result, word data from rs2
  assign data_req_o   = store_pending;
  assign data_we_o    = id_ex_i.is_store;
  assign data_addr_o  = alu_result;
  assign data_wdata_o = id_ex_i.store_data;

endmodule

// File: logic/core_top.sv
//////////////////////////////////////////////////////////////////////
// Core top level
// Fetch, decode and execute stages around the register file
// Plain OBI instruction and data bus ports
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module core_top #(
  parameter int FETCH_DEPTH = 2
) (
  input  logic            clk_i,
  input  logic            rst_i,
  input  logic            fetch_enable_i,
  input  core_pkg::word_t boot_addr_i,

  // Instruction bus
  output logic            instr_req_o,
  output core_pkg::word_t instr_addr_o,
  input  logic            instr_gnt_i,
  input  logic            instr_rvalid_i,
  input  core_pkg::word_t instr_rdata_i,

  // Data bus, stores only
  output logic            data_req_o,
  output logic            data_we_o,
  output core_pkg::word_t data_addr_o,
  output core_pkg::word_t data_wdata_o,
  input  logic            data_gnt_i
);
  import core_pkg::*;

  // Register file read side
  reg_addr_t rf_raddr_a;
  reg_addr_t rf_raddr_b;
  word_t     rf_rdata_a;
  word_t     rf_rdata_b;

  // Write-back from execute
  logic      wb_we;
  reg_addr_t wb_addr;
  word_t     wb_data;

  // Stage handoffs
  if_id_if i_if_id ();
  id_ex_if i_id_ex ();

  fetch_stage #(
    .FETCH_DEPTH    (FETCH_DEPTH)
  ) i_fetch_stage (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .fetch_enable_i (fetch_enable_i),
    .boot_addr_i    (boot_addr_i),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .if_id_o        (i_if_id)
  );

  decode_stage i_decode_stage (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .if_id_i   (i_if_id),
    .id_ex_o   (i_id_ex),
    .raddr_a_o (rf_raddr_a),
    .raddr_b_o (rf_raddr_b),
    .rdata_a_i (rf_rdata_a),
    .rdata_b_i (rf_rdata_b),
    .wb_we_i   (wb_we),
    .wb_addr_i (wb_addr),
    .wb_data_i (wb_data)
  );

  register_file i_register_file (
    .clk_i     (clk_i),
    .raddr_a_i (rf_raddr_a),
    .raddr_b_i (rf_raddr_b),
    .rdata_a_o (rf_rdata_a),
    .rdata_b_o (rf_rdata_b),
    .we_i      (wb_we),
    .waddr_i   (wb_addr),
    .wdata_i   (wb_data)
  );

  execute_stage i_execute_stage (
    .id_ex_i      (i_id_ex),
    .wb_we_o      (wb_we),
    .wb_addr_o    (wb_addr),
    .wb_data_o    (wb_data),
    .data_req_o   (data_req_o),
    .data_we_o    (data_we_o),
    .data_addr_o  (data_addr_o),
    .data_wdata_o (data_wdata_o),
    .data_gnt_i   (data_gnt_i)
  );

endmodule

// File: dv/tb_core_model.svh
//////////////////////////////////////////////////////////////////////
// Random program generator and reference model
// Instruction encoders, program memory lookup
// In-order ISA model producing the expected store list
//////////////////////////////////////////////////////////////////////

`ifndef TB_CORE_MODEL_SVH
`define TB_CORE_MODEL_SVH

  // Uniform value in 0 .. n-1 from the shared seed
  function automatic int unsigned rand_below(int unsigned n);
    int unsigned r;
    r = $random(seed);
    return r % n;
  endfunction

  function automatic word_t sext12(logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Encoders, RV32I field layout
  //////////////////////////////////////////////////////////////////////

  function automatic word_t enc_r(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                  logic [2:0] f3, reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic word_t enc_i(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                  reg_addr_t rd);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic word_t enc_u(logic [19:0] imm, reg_addr_t rd);
    return {imm, rd, 7'b0110111};
  endfunction

  // SW, offset split around the source fields
  function automatic word_t enc_sw(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  // Outside the program, memory reads as no-op
  function automatic word_t imem_read(word_t addr);
    if (addr >= BOOT_ADDR && addr < BOOT_ADDR + 4 * PROG_LEN && addr[1:0] == 2'b00) begin
      return prog[(addr - BOOT_ADDR) >> 2];
    end
    return NOP_INSTR;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Program generator
  //////////////////////////////////////////////////////////////////////

  function automatic void build_program();
    reg_addr_t   rd;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    logic [11:0] imm;
    int unsigned kind;
    for (int i = 0; i < PROG_LEN; i++) begin
      // Small indices, so results feed later sources often
      rd   = reg_addr_t'(rand_below(8));
      rs1  = reg_addr_t'(rand_below(8));
      rs2  = reg_addr_t'(rand_below(8));
      imm  = 12'(rand_below(4096));
      kind = rand_below(8);
      if (i < 7) begin
        // Prologue gives x1..x7 known values
        prog[i] = enc_i(imm, 5'd0, 3'b000, reg_addr_t'(i + 1));
      end else if (i == PROG_LEN - 1 || kind >= 6) begin
        prog[i] = enc_sw(imm, rs2, rs1);
      end else if (kind <= 2) begin
        case (rand_below(6))
          0:       prog[i] = enc_r(7'h00, rs2, rs1, 3'b000, rd);
          1:       prog[i] = enc_r(7'h20, rs2, rs1, 3'b000, rd);
          2:       prog[i] = enc_r(7'h00, rs2, rs1, 3'b111, rd);
          3:       prog[i] = enc_r(7'h00, rs2, rs1, 3'b110, rd);
          4:       prog[i] = enc_r(7'h00, rs2, rs1, 3'b100, rd);
          default: prog[i] = enc_r(7'h00, rs2, rs1, 3'b010, rd);
        endcase
      end else if (kind <= 4) begin
        case (rand_below(4))
          0:       prog[i] = enc_i(imm, rs1, 3'b000, rd);
          1:       prog[i] = enc_i(imm, rs1, 3'b100, rd);
          2:       prog[i] = enc_i(imm, rs1, 3'b110, rd);
          default: prog[i] = enc_i(imm, rs1, 3'b111, rd);
        endcase
      end else begin
        prog[i] = enc_u(20'(rand_below(1 << 20)), rd);
      end
    end
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  function automatic void run_model();
    word_t     regs [32];
    word_t     w;
    word_t     a;
    word_t     b;
    word_t     res;
    reg_addr_t rd;
    logic      wr;
    for (int r = 0; r < 32; r++) begin
      regs[r] = '0;
    end
    for (int i = 0; i < PROG_LEN; i++) begin
      w   = prog[i];
      a   = regs[w[19:15]];
      b   = regs[w[24:20]];
      rd  = w[11:7];
      wr  = 1'b0;
      res = '0;
      case (w[6:0])
        7'b0110011: begin
          wr = 1'b1;
          // funct7 and funct3 together pick the operation
          case ({w[31:25], w[14:12]})
            10'b0000000_000: res = a + b;
            10'b0100000_000: res = a - b;
            10'b0000000_111: res = a & b;
            10'b0000000_110: res = a | b;
            10'b0000000_100: res = a ^ b;
            10'b0000000_010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default:         wr  = 1'b0;
          endcase
        end
        7'b0010011: begin
          wr = 1'b1;
          case (w[14:12])
            3'b000:  res = a + sext12(w[31:20]);
            3'b100:  res = a ^ sext12(w[31:20]);
            3'b110:  res = a | sext12(w[31:20]);
            3'b111:  res = a & sext12(w[31:20]);
            default: wr  = 1'b0;
          endcase
        end
        7'b0110111: begin
          wr  = 1'b1;
          res = {w[31:12], 12'h000};
        end
        7'b0100011: begin
          if (w[14:12] == 3'b010) begin
            exp_addr_q.push_back(a + sext12({w[31:25], w[11:7]}));
            exp_data_q.push_back(b);
          end
        end
        default: ;
      endcase
      // x0 never changes
      if (wr && rd != 5'd0) begin
        regs[rd] = res;
      end
    end
  endfunction

`endif

// File: dv/tb_core_top.sv
//////////////////////////////////////////////////////////////////////
// Core testbench
// Clock, reset, random OBI instruction and data responders
// Fetch order, store stream and store count checks, watchdog
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_core_top;
  import core_pkg::*;

  localparam int    CLK_PERIOD      = 10;
  localparam int    PROG_LEN        = 200;
  localparam word_t BOOT_ADDR       = 32'h0000_0100;
  localparam int    WATCHDOG_CYCLES = PROG_LEN * 40;

  // DUT ports
  logic  clk_i;
  logic  rst_i;
  logic  fetch_enable_i;
  word_t boot_addr_i;
  logic  instr_req_o;
  word_t instr_addr_o;
  logic  instr_gnt_i;
  logic  instr_rvalid_i;
  word_t instr_rdata_i;
  logic  data_req_o;
  logic  data_we_o;
  word_t data_addr_o;
  word_t data_wdata_o;
  logic  data_gnt_i;

  // Program and expected stores
  integer seed = 32'h32e9;
  word_t  prog [PROG_LEN];
  word_t  exp_addr_q [$];
  word_t  exp_data_q [$];

  // Bus and progress state
  int     cycle           = 0;
  int     store_idx       = 0;
  int     data_stall      = 0;
  word_t  next_fetch_addr = BOOT_ADDR;
  word_t  rsp_addr_q [$];
  int     rsp_due_q [$];

  `include "tb_core_model.svh"

  core_top #(
    .FETCH_DEPTH    (2)
  ) i_dut (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .fetch_enable_i (fetch_enable_i),
    .boot_addr_i    (boot_addr_i),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .data_req_o     (data_req_o),
    .data_we_o      (data_we_o),
    .data_addr_o    (data_addr_o),
    .data_wdata_o   (data_wdata_o),
    .data_gnt_i     (data_gnt_i)
  );

  always begin
    #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  task automatic stop_on_failure();
    $display("FAIL: see errors above");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_equal(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
      $display("FAILED at %0t: %s, got %h, expected %h", $time, what, got, exp);
      stop_on_failure();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Bus responders
  //////////////////////////////////////////////////////////////////////

  // Instruction and data bus responders
  always @(posedge clk_i) begin
    if (rst_i) begin
      instr_gnt_i    <= 1'b0;
      instr_rvalid_i <= 1'b0;
      data_gnt_i     <= 1'b0;
    end else begin
      // Accepted fetch is answered 1 to 3 cycles later
      if (instr_req_o && instr_gnt_i) begin
        rsp_addr_q.push_back(instr_addr_o);
        rsp_due_q.push_back(cycle + int'(rand_below(3)));
      end
      instr_gnt_i <= (rand_below(4) != 0);
      if (rsp_due_q.size() > 0 && rsp_due_q[0] <= cycle) begin
        instr_rvalid_i <= 1'b1;
        instr_rdata_i  <= imem_read(rsp_addr_q.pop_front());
        void'(rsp_due_q.pop_front());
      end else begin
        instr_rvalid_i <= 1'b0;
        instr_rdata_i  <= NOP_INSTR;
      end
      // Stall length counted in cycles with a pending store
      if (data_req_o && data_gnt_i) begin
        data_stall = int'(rand_below(5));
      end else if (data_req_o && data_stall > 0) begin
        data_stall = data_stall - 1;
      end
      data_gnt_i <= (data_stall == 0);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Monitors
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    cycle <= cycle + 1;
    // Quiet buses through reset and the first idle cycle
    if (cycle > 0 && !fetch_enable_i) begin
      check_equal(word_t'(instr_req_o), 32'd0, "instr_req_o before fetch enable");
      check_equal(word_t'(data_req_o), 32'd0, "data_req_o before fetch enable");
    end
    if (!rst_i && instr_req_o && instr_gnt_i) begin
      check_equal(instr_addr_o, next_fetch_addr, "granted fetch address");
      next_fetch_addr = next_fetch_addr + 32'd4;
    end
    if (!rst_i && data_req_o) begin
      check_equal(word_t'(data_we_o), 32'd1, "data_we_o on store request");
    end
    if (!rst_i && data_req_o && data_gnt_i) begin
      if (store_idx >= exp_addr_q.size()) begin
        $display("Extra store at %0t to %h beyond the %0d expected stores",
                 $time, data_addr_o, exp_addr_q.size());
        stop_on_failure();
      end else begin
        check_equal(data_addr_o, exp_addr_q[store_idx],
                    $sformatf("store %0d address", store_idx));
        check_equal(data_wdata_o, exp_data_q[store_idx],
                    $sformatf("store %0d data", store_idx));
        store_idx <= store_idx + 1;
      end
    end
  end

  // Watchdog allows 40 cycles per program instruction
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles with %0d of %0d stores seen",
             WATCHDOG_CYCLES, store_idx, exp_addr_q.size());
    stop_on_failure();
  end

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    clk_i          = 1'b0;
    rst_i          = 1'b1;
    fetch_enable_i = 1'b0;
    boot_addr_i    = BOOT_ADDR;
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = NOP_INSTR;
    data_gnt_i     = 1'b0;
    build_program();
    run_model();
    $display("Program of %0d instructions, %0d expected stores",
             PROG_LEN, exp_addr_q.size());
    repeat (5) @(posedge clk_i);
    rst_i <= 1'b0;
    @(posedge clk_i);
    fetch_enable_i <= 1'b1;
    while (store_idx < exp_addr_q.size()) begin
      @(posedge clk_i);
    end
    // Trailing no-ops must not produce further stores
    repeat (20) @(posedge clk_i);
    $display("PASS: all tests");
    $finish;
  end

endmodule

// File: core_top.f
+incdir+dv
logic/core_pkg.sv
logic/if_id_if.sv
logic/id_ex_if.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/register_file.sv
logic/execute_stage.sv
logic/core_top.sv
dv/tb_core_top.sv

// File: run.sh
#!/bin/sh
# Build and run the core testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  -f core_top.f \
  --top-module tb_core_top \
  -o tb_core_top

./obj_dir/tb_core_top
